/* project.f */
+incdir+include
verilog/console_usb_pkg.sv
verilog/console_dev_regs.sv
verilog/console_usb_dev.sv
verilog/console_usb_top.sv
dv/console_usb_checker.sv
dv/console_usb_tb.sv

/* dv/console_usb_tests.txt */
# op name f1 f2 f3 f4 (hex)
# LINK: stat btype cmd dstat | TYPE/TEMP/DATA: stat read_seen 0 dstat | SEND: bag btype cmd dstat
# FAIL: pulses 0 0 dstat | REGW: addr data 0 0 | REGR: addr expected 0 0
REGW cfg_dev 0 00000053 0 0
REGW cfg_cmd 1 00000a5c 0 0
REGR read_cfg_dev 0 00000053 0 0
REGR read_cfg_cmd 1 00000a5c 0 0
LINK link_up 00000000 5 30000000 000
TYPE type_c0 00c00000 1 0 100
TYPE type_f0 00f00000 1 0 200
TYPE type_ff 00ff0000 1 0 300
TEMP temp_5a 5a000000 1 0 35a
TYPE type_c0_again 00c00000 1 0 15a
DATA data_ok 00008300 1 0 15a
DATA data_other_idx 00008400 0 0 15a
SEND send_conf 1 6 35a5c000 15a
REGW cfg_cmd_2 1 00000123 0 0
SEND send_conv 9 7 35123000 15a
REGW cfg_dev_2 0 00000027 0 0
SEND send_clink b 4 72123000 15a
DATA data_bad_link 0000f700 1 0 05a
REGR read_stat 2 0000005a 0 0
LINK relink 00000000 5 70000000 15a
FAIL fail_four 4 0 0 05a
REGR read_fails 3 00000004 0 0
REGW clear_fails 3 00000000 0 0
REGR read_fails_clr 3 00000000 0 0

/* dv/console_usb_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "console_usb_settings.svh"

module console_usb_tb;

    logic                       clk;
    logic                       rst;
    logic                       reg_wr;
    logic [1:0]                 reg_addr;
    logic [31:0]                reg_wdata;
    logic [31:0]                reg_rdata;
    logic                       fs_send;
    logic                       fd_send;
    logic                       fs_read;
    logic                       fd_read;
    logic                       fs_usb_send;
    logic                       fd_usb_send;
    logic                       ff_usb_send;
    logic                       fs_usb_read;
    logic                       fd_usb_read;
    console_usb_pkg::send_bag_e send_btype;
    console_usb_pkg::read_bag_e read_btype;
    console_usb_pkg::send_bag_e send_usb_btype;
    console_usb_pkg::read_bag_e read_usb_btype;
    console_usb_pkg::usb_cmd_t  usb_cmd;
    console_usb_pkg::usb_stat_t usb_stat;

    string       t_op[$];
    string       t_name[$];
    logic [31:0] t_f1[$], t_f2[$], t_f3[$], t_f4[$];
    int          value_errors = 0;
    int          timeout_errors = 0;
    int          fail_req = 0;
    int          fail_done = 0;
    bit          tests_loaded = 0;

    console_usb_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic advance_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic check_stat(input string name, input console_usb_pkg::dev_stat_t exp,
                              input console_usb_pkg::dev_stat_t act);
        if (exp !== act) begin
            $display("ERROR %s: dev_stat expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_cmd(input string name, input console_usb_pkg::usb_cmd_t exp,
                             input console_usb_pkg::usb_cmd_t act);
        if (exp !== act) begin
            $display("ERROR %s: usb_cmd expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_btype(input string name, input console_usb_pkg::send_bag_e exp,
                               input console_usb_pkg::send_bag_e act);
        if (exp !== act) begin
            $display("ERROR %s: send_usb_btype expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: data expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic wait_usb_send(input string name, input logic level);
        int n;
        n = 0;
        while (fs_usb_send !== level && n < 40) begin
            advance_cycle();
            n++;
        end
        if (fs_usb_send !== level) begin
            $display("%s: the agent did not change its usb send request in time", name);
            timeout_errors++;
        end
    endtask

    task automatic wait_fd_send(input string name, input logic level);
        int n;
        n = 0;
        while (fd_send !== level && n < 40) begin
            advance_cycle();
            n++;
        end
        if (fd_send !== level) begin
            $display("%s: the agent did not change its send done in time", name);
            timeout_errors++;
        end
    endtask

    // usb side raises a packet and holds it until the agent takes it
    task automatic present_packet(input string name);
        int n;
        n = 0;
        fs_usb_read = 1'b1;
        advance_cycle();
        while (fd_usb_read !== 1'b1 && n < 40) begin
            advance_cycle();
            n++;
        end
        if (fd_usb_read !== 1'b1) begin
            $display("%s: the agent never took the usb packet", name);
            timeout_errors++;
        end
        fs_usb_read = 1'b0;
    endtask

    // console read side, answers a read request with one fd_read pulse
    task automatic console_read(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < `CONSOLE_READ_TIMEOUT) begin
            advance_cycle();
            seen = (fs_read === 1'b1);
            n++;
        end
        if (seen) begin
            fd_read = 1'b1;
            advance_cycle();
            fd_read = 1'b0;
        end
    endtask

    task automatic run_test(input string op, input string name, input logic [31:0] f1,
                            input logic [31:0] f2, input logic [31:0] f3,
                            input logic [31:0] f4);
        bit seen;
        case (op)
            "LINK", "TYPE", "TEMP", "DATA": begin
                usb_stat = f1;
                read_btype = console_usb_pkg::BAG_DATA;
                case (op)
                    "LINK": read_usb_btype = console_usb_pkg::BAG_DLINK;
                    "TYPE": read_usb_btype = console_usb_pkg::BAG_DTYPE;
                    "TEMP": begin
                        read_usb_btype = console_usb_pkg::BAG_DTEMP;
                        read_btype = console_usb_pkg::BAG_DTEMP;
                    end
                    default: read_usb_btype = console_usb_pkg::BAG_DATA0;
                endcase
                present_packet(name);
                if (op == "LINK") begin
                    wait_usb_send(name, 1'b1);
                    check_btype(name, console_usb_pkg::send_bag_e'(f2[3:0]), send_usb_btype);
                    check_cmd(name, f3, usb_cmd);
                    wait_usb_send(name, 1'b0);
                end else begin
                    console_read(seen);
                    check_word(name, f2, {31'd0, seen});
                end
            end
            "SEND": begin
                send_btype = console_usb_pkg::send_bag_e'(f1[3:0]);
                fs_send = 1'b1;
                wait_fd_send(name, 1'b1);
                check_btype(name, console_usb_pkg::send_bag_e'(f2[3:0]), send_usb_btype);
                check_cmd(name, f3, usb_cmd);
                fs_send = 1'b0;
                wait_fd_send(name, 1'b0);
            end
            "FAIL": begin
                fail_req = fail_req + f1;
                while (fail_done != fail_req) advance_cycle();
            end
            "REGW": begin
                reg_addr = f1[1:0];
                reg_wdata = f2;
                reg_wr = 1'b1;
                advance_cycle();
                reg_wr = 1'b0;
            end
            "REGR": begin
                reg_addr = f1[1:0];
                advance_cycle();
                check_word(name, f2, reg_rdata);
            end
            default: begin
                $display("%s: unknown test op %s in the test file", name, op);
                value_errors++;
            end
        endcase
        repeat (12) advance_cycle();
        if (op != "REGW" && op != "REGR") begin
            check_stat(name, console_usb_pkg::dev_stat_t'(f4[9:0]), DUT.dev_stat);
        end
    endtask

    // usb model responder for send acknowledges and failure pulses
    initial begin
        int delay;
        bit busy;
        fd_usb_send = 1'b0;
        ff_usb_send = 1'b0;
        busy = 1'b0;
        delay = 0;
        forever begin
            advance_cycle();
            if (fd_usb_send) begin
                fd_usb_send = 1'b0;
                ff_usb_send = 1'b0;
            end else if (busy) begin
                if (delay == 0) begin
                    fd_usb_send = 1'b1;
                    busy = 1'b0;
                end else begin
                    delay--;
                end
            end else if (fs_usb_send) begin
                busy = 1'b1;
                delay = $urandom % 5;
            end else if (fail_done != fail_req) begin
                // done strobe rides with the failure strobe, so no clearing cycle
                ff_usb_send = 1'b1;
                fd_usb_send = 1'b1;
                fail_done++;
            end
        end
    end

    initial begin
        wait (tests_loaded);
        repeat (200 * t_op.size()) @(posedge clk);
        $display("the run timed out before all tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int          fd;
        int          r;
        int          seed;
        string       line;
        string       op;
        string       nm;
        logic [31:0] f1, f2, f3, f4;
        int          asserts;
        rst = 1'b1;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        fs_send = 1'b0;
        fd_read = 1'b0;
        fs_usb_read = 1'b0;
        send_btype = console_usb_pkg::BAG_INIT;
        read_btype = console_usb_pkg::BAG_DATA;
        read_usb_btype = console_usb_pkg::BAG_DATA;
        usb_stat = '0;
        seed = $urandom(46260);
        fd = $fopen("dv/console_usb_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                if (line.len() > 2 && line[0] != "#") begin
                    r = $sscanf(line, "%s %s %h %h %h %h", op, nm, f1, f2, f3, f4);
                    if (r == 6) begin
                        t_op.push_back(op);
                        t_name.push_back(nm);
                        t_f1.push_back(f1);
                        t_f2.push_back(f2);
                        t_f3.push_back(f3);
                        t_f4.push_back(f4);
                    end
                end
            end
            $fclose(fd);
            tests_loaded = 1'b1;
            repeat (5) @(posedge clk);
            #0.5;
            rst = 1'b0;
            repeat (3) advance_cycle();
            for (int i = 0; i < t_op.size(); i++) begin
                run_test(t_op[i], t_name[i], t_f1[i], t_f2[i], t_f3[i], t_f4[i]);
            end
            asserts = DUT.u_dev.u_checker.assert_errors;
            $display("tests %0d, value errors %0d, timeouts %0d, assertion errors %0d",
                     t_op.size(), value_errors, timeout_errors, asserts);
            if (value_errors == 0 && timeout_errors == 0 && asserts == 0 && t_op.size() > 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* dv/console_usb_checker.sv */
`timescale 1ns/100ps
`default_nettype none
`include "console_usb_settings.svh"

module console_usb_checker (
    input  logic clk,
    input  logic rst,
    input  logic fs_usb_send,
    input  logic fd_usb_send,
    input  logic fd_usb_read,
    input  logic fs_com_read,
    input  logic dev_link
);

    int assert_errors = 0;

    // usb send request is held until the model acknowledges it
    property send_held;
        @(posedge clk) disable iff (rst)
        (fs_usb_send && !fd_usb_send) |=> fs_usb_send;
    endproperty

    // no usb read is taken during or right after an unanswered send request
    property read_send_exclusive;
        @(posedge clk) disable iff (rst)
        fd_usb_read |-> (!fs_usb_send && !$past(fs_usb_send && !fd_usb_send));
    endproperty

    // console read request is bounded by the read timeout
    property read_bounded;
        @(posedge clk) disable iff (rst)
        (dev_link && $rose(fs_com_read)) |-> ##[1:`CONSOLE_READ_TIMEOUT + 2] !fs_com_read;
    endproperty

    a_send_held: assert property (send_held) else begin
        $error("fs_usb_send dropped before fd_usb_send");
        assert_errors++;
    end

    a_read_send_exclusive: assert property (read_send_exclusive) else begin
        $error("fd_usb_read raised while a usb send request was outstanding");
        assert_errors++;
    end

    a_read_bounded: assert property (read_bounded) else begin
        $error("console read request held past the timeout");
        assert_errors++;
    end

endmodule

bind console_usb_dev console_usb_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .fs_usb_send (fs_usb_send),
    .fd_usb_send (fd_usb_send),
    .fd_usb_read (fd_usb_read),
    .fs_com_read (fs_com_read),
    .dev_link    (dev_link)
);

`default_nettype wire

/* verilog/console_usb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module console_usb_top (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       reg_wr,
    input  logic [1:0]                 reg_addr,
    input  logic [31:0]                reg_wdata,
    output logic [31:0]                reg_rdata,

    input  logic                       fs_send,
    output logic                       fd_send,
    output logic                       fs_read,
    input  logic                       fd_read,

    output logic                       fs_usb_send,
    input  logic                       fd_usb_send,
    input  logic                       ff_usb_send,
    input  logic                       fs_usb_read,
    output logic                       fd_usb_read,

    input  console_usb_pkg::send_bag_e send_btype,
    input  console_usb_pkg::read_bag_e read_btype,
    output console_usb_pkg::send_bag_e send_usb_btype,
    input  console_usb_pkg::read_bag_e read_usb_btype,

    output console_usb_pkg::usb_cmd_t  usb_cmd,
    input  console_usb_pkg::usb_stat_t usb_stat
);

    console_usb_pkg::dev_cfg_t  cfg;
    console_usb_pkg::dev_stat_t dev_stat;

    console_dev_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .ff_usb_send (ff_usb_send),
        .dev_stat    (dev_stat),
        .cfg         (cfg)
    );

    console_usb_dev u_dev (
        .clk            (clk),
        .rst            (rst),
        .fs_send        (fs_send),
        .fd_send        (fd_send),
        .fs_read        (fs_read),
        .fd_read        (fd_read),
        .fs_usb_send    (fs_usb_send),
        .fd_usb_send    (fd_usb_send),
        .ff_usb_send    (ff_usb_send),
        .fs_usb_read    (fs_usb_read),
        .fd_usb_read    (fd_usb_read),
        .send_btype     (send_btype),
        .read_btype     (read_btype),
        .send_usb_btype (send_usb_btype),
        .read_usb_btype (read_usb_btype),
        .cfg            (cfg),
        .usb_cmd        (usb_cmd),
        .usb_stat       (usb_stat),
        .dev_stat       (dev_stat)
    );

endmodule

`default_nettype wire

/* verilog/console_usb_dev.sv */
`timescale 1ns/100ps
`default_nettype none
`include "console_usb_settings.svh"

module console_usb_dev (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       fs_send,
    output logic                       fd_send,
    output logic                       fs_read,
    input  logic                       fd_read,

    output logic                       fs_usb_send,
    input  logic                       fd_usb_send,
    input  logic                       ff_usb_send,
    input  logic                       fs_usb_read,
    output logic                       fd_usb_read,

    input  console_usb_pkg::send_bag_e send_btype,
    input  console_usb_pkg::read_bag_e read_btype,
    output console_usb_pkg::send_bag_e send_usb_btype,
    input  console_usb_pkg::read_bag_e read_usb_btype,

    input  console_usb_pkg::dev_cfg_t  cfg,
    output console_usb_pkg::usb_cmd_t  usb_cmd,
    input  console_usb_pkg::usb_stat_t usb_stat,
    output console_usb_pkg::dev_stat_t dev_stat
);

    localparam int FAIL_W = $clog2(`CONSOLE_FAIL_LIMIT + 1);

    console_usb_pkg::dev_state_e state;
    console_usb_pkg::dev_state_e next_state;
    console_usb_pkg::dev_type_e  dev_type;

    logic [7:0]        dev_temp;
    logic              dev_link;
    logic              cri_stat;
    logic              fd_com_send;
    logic              fs_com_read;
    logic              read_expired;
    logic [7:0]        read_wait;
    logic [1:0]        ff_sync;
    logic [FAIL_W-1:0] fail_cnt;

    // data link nibble must agree with the type class, unknown class accepts any
    function automatic logic link_fits(input console_usb_pkg::dev_type_e dtype,
                                       input logic [3:0] link);
        logic fits;
        case (dtype)
            console_usb_pkg::DEV_C0: fits = (link == `LINK_CODE_C0);
            console_usb_pkg::DEV_F0: fits = (link == `LINK_CODE_F0);
            console_usb_pkg::DEV_FF: fits = (link == `LINK_CODE_FF);
            default:                 fits = 1'b1;
        endcase
        return fits;
    endfunction

    assign cri_stat     = (usb_stat.idx == cfg.device_idx);
    assign read_expired = (read_wait == 8'(`CONSOLE_READ_TIMEOUT));

    assign fd_com_send = (state == console_usb_pkg::CONF_DONE) ||
                         (state == console_usb_pkg::CONV_DONE) ||
                         (state == console_usb_pkg::IDLE_DONE);
    assign fs_com_read = (state == console_usb_pkg::TYPE_DONE) ||
                         (state == console_usb_pkg::TEMP_DONE) ||
                         (state == console_usb_pkg::DATA_DONE);
    assign fs_usb_send = (state == console_usb_pkg::DIDX_WORK) ||
                         (state == console_usb_pkg::CONF_WORK) ||
                         (state == console_usb_pkg::CONV_WORK) ||
                         (state == console_usb_pkg::IDLE_WORK);
    assign fd_usb_read = (state == console_usb_pkg::MAIN_TAKE);

    // unlinked: send requests complete at once, reads just echo the console
    assign fd_send = (state != console_usb_pkg::MAIN_IDLE) && (dev_link ? fd_com_send : 1'b1);
    assign fs_read = dev_link ? fs_com_read : ~fd_read;

    assign dev_stat.dtype = dev_link ? dev_type : console_usb_pkg::DEV_NONE;
    assign dev_stat.temp  = dev_temp;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= console_usb_pkg::MAIN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            console_usb_pkg::MAIN_IDLE: next_state = console_usb_pkg::MAIN_WAIT;
            console_usb_pkg::MAIN_WAIT: begin
                // usb traffic wins over console requests
                if (fs_usb_read) begin
                    next_state = console_usb_pkg::MAIN_TAKE;
                end else if (fs_send) begin
                    next_state = console_usb_pkg::MAIN_DOOR;
                end
            end
            console_usb_pkg::MAIN_TAKE: begin
                if (!fs_usb_read) next_state = console_usb_pkg::MAIN_WORK;
            end
            console_usb_pkg::MAIN_WORK: begin
                case (read_usb_btype)
                    console_usb_pkg::BAG_DLINK: next_state = console_usb_pkg::LINK_IDLE;
                    console_usb_pkg::BAG_DTYPE: next_state = console_usb_pkg::TYPE_IDLE;
                    console_usb_pkg::BAG_DTEMP: next_state = console_usb_pkg::TEMP_IDLE;
                    console_usb_pkg::BAG_DATA0: next_state = console_usb_pkg::DATA_IDLE;
                    console_usb_pkg::BAG_DATA1: next_state = console_usb_pkg::DATA_IDLE;
                    default:                    next_state = console_usb_pkg::MAIN_WAIT;
                endcase
            end
            console_usb_pkg::MAIN_DOOR: begin
                case (send_btype)
                    console_usb_pkg::BAG_DCONF: next_state = console_usb_pkg::CONF_IDLE;
                    console_usb_pkg::BAG_DCONV: next_state = console_usb_pkg::CONV_IDLE;
                    console_usb_pkg::BAG_CLINK: next_state = console_usb_pkg::IDLE_IDLE;
                    default:                    next_state = console_usb_pkg::MAIN_WAIT;
                endcase
            end

            console_usb_pkg::LINK_IDLE: next_state = console_usb_pkg::LINK_TAKE;
            console_usb_pkg::LINK_TAKE: next_state = console_usb_pkg::DIDX_WAIT;
            console_usb_pkg::DIDX_WAIT: next_state = console_usb_pkg::DIDX_WORK;
            console_usb_pkg::DIDX_WORK: begin
                if (fd_usb_send) next_state = console_usb_pkg::MAIN_WAIT;
            end

            console_usb_pkg::TYPE_IDLE: next_state = console_usb_pkg::TYPE_TAKE;
            console_usb_pkg::TYPE_TAKE: next_state = console_usb_pkg::TYPE_DONE;
            console_usb_pkg::TEMP_IDLE: next_state = console_usb_pkg::TEMP_TAKE;
            console_usb_pkg::TEMP_TAKE: next_state = console_usb_pkg::TEMP_DONE;
            console_usb_pkg::DATA_IDLE: next_state = console_usb_pkg::DATA_TAKE;
            console_usb_pkg::DATA_TAKE: begin
                // packets for another device are dropped here
                next_state = cri_stat ? console_usb_pkg::DATA_DONE : console_usb_pkg::MAIN_WAIT;
            end
            console_usb_pkg::TYPE_DONE,
            console_usb_pkg::TEMP_DONE,
            console_usb_pkg::DATA_DONE: begin
                if (fd_read || read_expired) next_state = console_usb_pkg::MAIN_WAIT;
            end

            console_usb_pkg::CONF_IDLE: next_state = console_usb_pkg::CONF_WAIT;
            console_usb_pkg::CONF_WAIT: next_state = console_usb_pkg::CONF_WORK;
            console_usb_pkg::CONV_IDLE: next_state = console_usb_pkg::CONV_WAIT;
            console_usb_pkg::CONV_WAIT: next_state = console_usb_pkg::CONV_WORK;
            console_usb_pkg::IDLE_IDLE: next_state = console_usb_pkg::IDLE_WAIT;
            console_usb_pkg::IDLE_WAIT: next_state = console_usb_pkg::IDLE_WORK;
            console_usb_pkg::CONF_WORK: begin
                if (fd_usb_send) next_state = console_usb_pkg::CONF_DONE;
            end
            console_usb_pkg::CONV_WORK: begin
                if (fd_usb_send) next_state = console_usb_pkg::CONV_DONE;
            end
            console_usb_pkg::IDLE_WORK: begin
                if (fd_usb_send) next_state = console_usb_pkg::IDLE_DONE;
            end
            console_usb_pkg::CONF_DONE,
            console_usb_pkg::CONV_DONE,
            console_usb_pkg::IDLE_DONE: begin
                if (!fs_send) next_state = console_usb_pkg::MAIN_WAIT;
            end

            default: next_state = console_usb_pkg::MAIN_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            usb_cmd <= '0;
        end else if (state == console_usb_pkg::LINK_IDLE) begin
            usb_cmd            <= '0;
            usb_cmd.device_idx <= cfg.device_idx;
        end else if (state == console_usb_pkg::MAIN_DOOR) begin
            usb_cmd.device_idx <= cfg.device_idx;
            usb_cmd.data_idx   <= cfg.data_idx;
            usb_cmd.com_cmd    <= cfg.com_cmd;
            usb_cmd.reserved   <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            send_usb_btype <= console_usb_pkg::BAG_INIT;
        end else begin
            case (state)
                console_usb_pkg::DIDX_WAIT: send_usb_btype <= console_usb_pkg::BAG_DIDX;
                console_usb_pkg::CONF_WAIT: send_usb_btype <= console_usb_pkg::BAG_DPARAM;
                console_usb_pkg::CONV_WAIT: send_usb_btype <= console_usb_pkg::BAG_DDIDX;
                console_usb_pkg::IDLE_WAIT: send_usb_btype <= console_usb_pkg::BAG_LINK;
                default:                    send_usb_btype <= send_usb_btype;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dev_temp <= '0;
            dev_type <= console_usb_pkg::DEV_NONE;
        end else if (state == console_usb_pkg::TEMP_TAKE) begin
            dev_temp <= usb_stat.temp;
        end else if (state == console_usb_pkg::TYPE_TAKE) begin
            case (usb_stat.type_byte)
                `TYPE_CODE_C0: dev_type <= console_usb_pkg::DEV_C0;
                `TYPE_CODE_F0: dev_type <= console_usb_pkg::DEV_F0;
                `TYPE_CODE_FF: dev_type <= console_usb_pkg::DEV_FF;
                default:       dev_type <= dev_type;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dev_link <= 1'b0;
        end else if (state == console_usb_pkg::MAIN_IDLE) begin
            dev_link <= 1'b0;
        end else if (state == console_usb_pkg::LINK_TAKE) begin
            dev_link <= 1'b1;
        end else if ((state == console_usb_pkg::TEMP_TAKE) &&
                     (read_btype != console_usb_pkg::BAG_DTEMP)) begin
            dev_link <= 1'b0;
        end else if ((state == console_usb_pkg::DATA_TAKE) &&
                     ((read_btype != console_usb_pkg::BAG_DATA) ||
                      !link_fits(dev_type, usb_stat.link))) begin
            dev_link <= 1'b0;
        end else if (fail_cnt == FAIL_W'(`CONSOLE_FAIL_LIMIT)) begin
            dev_link <= 1'b0;
        end
    end

    // failure line comes from another domain in the real system
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ff_sync <= 2'b00;
        end else begin
            ff_sync <= {ff_sync[0], ff_usb_send};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fail_cnt <= '0;
        end else if ((state == console_usb_pkg::MAIN_IDLE) || !dev_link) begin
            fail_cnt <= '0;
        end else if (ff_sync == 2'b01) begin
            fail_cnt <= fail_cnt + 1'b1;
        end else if (ff_usb_send ^ fd_usb_send) begin
            fail_cnt <= '0;
        end
    end

    // counts cycles spent waiting on the console read side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_wait <= '0;
        end else if (fs_com_read) begin
            read_wait <= read_wait + 8'd1;
        end else begin
            read_wait <= '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/console_dev_regs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "console_usb_settings.svh"

module console_dev_regs (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       reg_wr,
    input  logic [1:0]                 reg_addr,
    input  logic [31:0]                reg_wdata,
    output logic [31:0]                reg_rdata,

    input  logic                       ff_usb_send,
    input  console_usb_pkg::dev_stat_t dev_stat,
    output console_usb_pkg::dev_cfg_t  cfg
);

    logic        ff_q;
    logic        fail_edge;
    logic        fail_clr;
    logic [15:0] fail_cnt;

    assign fail_edge = ff_usb_send & ~ff_q;
    assign fail_clr  = reg_wr && (reg_addr == `REG_FAILS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                `REG_CFG_DEV: begin
                    cfg.device_idx <= reg_wdata[3:0];
                    cfg.data_idx   <= reg_wdata[7:4];
                end
                `REG_CFG_CMD: begin
                    cfg.com_cmd <= reg_wdata[11:0];
                end
                default: begin
                    cfg <= cfg;
                end
            endcase
        end
    end

    // failure pulses, saturating so a stuck line does not wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ff_q     <= 1'b0;
            fail_cnt <= '0;
        end else begin
            ff_q <= ff_usb_send;
            if (fail_clr) begin
                fail_cnt <= '0;
            end else if (fail_edge && (fail_cnt != 16'hFFFF)) begin
                fail_cnt <= fail_cnt + 16'd1;
            end
        end
    end

    always_comb begin
        case (reg_addr)
            `REG_CFG_DEV: reg_rdata = {24'd0, cfg.data_idx, cfg.device_idx};
            `REG_CFG_CMD: reg_rdata = {20'd0, cfg.com_cmd};
            `REG_STAT:    reg_rdata = {22'd0, dev_stat};
            `REG_FAILS:   reg_rdata = {16'd0, fail_cnt};
            default:      reg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/console_usb_pkg.sv */
`default_nettype none

package console_usb_pkg;

    typedef enum logic [4:0] {
        MAIN_IDLE, MAIN_WAIT, MAIN_TAKE, MAIN_WORK, MAIN_DOOR,
        LINK_IDLE, LINK_TAKE, DIDX_WAIT, DIDX_WORK,
        TYPE_IDLE, TYPE_TAKE, TYPE_DONE,
        TEMP_IDLE, TEMP_TAKE, TEMP_DONE,
        DATA_IDLE, DATA_TAKE, DATA_DONE,
        CONF_IDLE, CONF_WAIT, CONF_WORK, CONF_DONE,
        CONV_IDLE, CONV_WAIT, CONV_WORK, CONV_DONE,
        IDLE_IDLE, IDLE_WAIT, IDLE_WORK, IDLE_DONE
    } dev_state_e;

    // packets coming in from usb or the console read side
    typedef enum logic [3:0] {
        BAG_DLINK = 4'b1000,
        BAG_DTYPE = 4'b1001,
        BAG_DTEMP = 4'b1010,
        BAG_DATA0 = 4'b1101,
        BAG_DATA1 = 4'b1110,
        BAG_DATA  = 4'b0101
    } read_bag_e;

    // packets going out, plus the console send requests
    typedef enum logic [3:0] {
        BAG_INIT   = 4'b0000,
        BAG_LINK   = 4'b0100,
        BAG_DIDX   = 4'b0101,
        BAG_DPARAM = 4'b0110,
        BAG_DDIDX  = 4'b0111,
        BAG_DCONF  = 4'b0001,
        BAG_DCONV  = 4'b1001,
        BAG_CLINK  = 4'b1011
    } send_bag_e;

    typedef enum logic [1:0] {
        DEV_NONE = 2'd0,
        DEV_C0   = 2'd1,
        DEV_F0   = 2'd2,
        DEV_FF   = 2'd3
    } dev_type_e;

    typedef struct packed {
        logic [7:0] temp;
        logic [7:0] type_byte;
        logic [3:0] link;
        logic [3:0] idx;
        logic [3:0] didx;
        logic [3:0] reserved;
    } usb_stat_t;

    typedef struct packed {
        logic [3:0]  device_idx;
        logic [3:0]  data_idx;
        logic [11:0] com_cmd;
        logic [11:0] reserved;
    } usb_cmd_t;

    typedef struct packed {
        dev_type_e  dtype;
        logic [7:0] temp;
    } dev_stat_t;

    typedef struct packed {
        logic [3:0]  device_idx;
        logic [3:0]  data_idx;
        logic [11:0] com_cmd;
    } dev_cfg_t;

endpackage

`default_nettype wire

/* include/console_usb_settings.svh */
`ifndef CONSOLE_USB_SETTINGS_SVH
`define CONSOLE_USB_SETTINGS_SVH

// console read side wait and link drop threshold
`define CONSOLE_READ_TIMEOUT 8
`define CONSOLE_FAIL_LIMIT   4

// type bytes reported by the device
`define TYPE_CODE_C0 8'hC0
`define TYPE_CODE_F0 8'hF0
`define TYPE_CODE_FF 8'hFF

// link nibble expected in data packets for each type class
`define LINK_CODE_C0 4'h8
`define LINK_CODE_F0 4'hC
`define LINK_CODE_FF 4'hF

`define REG_CFG_DEV 2'd0
`define REG_CFG_CMD 2'd1
`define REG_STAT    2'd2
`define REG_FAILS   2'd3

`endif
